// File: Bender.yml
package:
  name: dbus_unit

sources:
  - design/dbus_pkg.sv
  - design/access_router.sv
  - design/burst_engine.sv
  - design/peri_master.sv
  - design/dbus_unit.sv
  - target: test
    files:
      - tests/dbus_unit_checker.sv
      - tests/tb_dbus_unit.sv

// File: dbus_unit.f
design/dbus_pkg.sv
design/access_router.sv
design/burst_engine.sv
design/peri_master.sv
design/dbus_unit.sv
tests/dbus_unit_checker.sv
tests/tb_dbus_unit.sv

// File: design/access_router.sv
// Address decoder for memory-stage accesses
// Steers read/write strobes to peripheral or cache side
// Selects the returned read word

`timescale 1ns/10ps
`default_nettype none

module access_router #(
	// Highest peripheral address, inclusive
	parameter dbus_pkg::addr_t PERI_BOUNDARY = 32'h011C
) (
	input  wire dbus_pkg::cpu_acc_t i_acc,
	input  wire dbus_pkg::word_t    i_peri_rdata,
	input  wire dbus_pkg::word_t    i_dmem_rdata,
	output logic                    o_peri_rd,
	output logic                    o_peri_wr,
	output logic                    o_mem_rd,
	output logic                    o_mem_wr,
	output dbus_pkg::word_t         o_rdata
);

	// Peripheral space sits at the bottom of the map
	logic peri_hit;

	assign peri_hit = (i_acc.addr <= PERI_BOUNDARY);

	// ==================================================
	// Strobe steering
	// ==================================================
	always_comb begin
		o_peri_rd = 1'b0;
		o_peri_wr = 1'b0;
		o_mem_rd  = 1'b0;
		o_mem_wr  = 1'b0;
		// Read side
		if (i_acc.read) begin
			if (peri_hit)
				o_peri_rd = 1'b1;
			else
				o_mem_rd = 1'b1;
		end
		// Write side
		if (i_acc.write) begin
			if (peri_hit)
				o_peri_wr = 1'b1;
			else
				o_mem_wr = 1'b1;
		end
	end

	// ==================================================
	// Read data return
	// ==================================================

	// Same decode as the strobes, no extra state
	assign o_rdata = peri_hit ? i_peri_rdata : i_dmem_rdata;

endmodule

`default_nettype wire

// File: design/burst_engine.sv
// Dual-bank WRAP8 burst master
// Line refill into the cache, dirty-line writeback out of it
// Error flag for skewed readiness and for hresp

`timescale 1ns/10ps
`default_nettype none

module burst_engine (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                i_refill_req,
	input  wire logic                i_wb_req,
	input  wire dbus_pkg::addr_t     i_addr,
	input  wire dbus_pkg::word_t     i_dirty_w1,
	input  wire dbus_pkg::word_t     i_dirty_w2,
	input  wire dbus_pkg::ahb_slv_t  i_bank1,
	input  wire dbus_pkg::ahb_slv_t  i_bank2,
	output dbus_pkg::ahb_mst_t       o_bank1,
	output dbus_pkg::ahb_mst_t       o_bank2,
	output dbus_pkg::line_upd_t      o_line,
	output logic                     o_wb_done,
	output logic                     o_data_err
);

	localparam dbus_pkg::beat_t LAST_BEAT = 3'd7;

	dbus_pkg::htrans_e state_q;
	dbus_pkg::htrans_e state_d;
	// Beats done so far, and wrapping index on the bus
	dbus_pkg::beat_t   cnt_q;
	dbus_pkg::beat_t   idx_q;
	dbus_pkg::addr_t   addr_q;
	// High for a writeback burst
	logic              write_q;
	logic              start;
	logic              active;
	logic              both_ready;
	logic              ready_skew;
	logic              beat_fail;
	logic              beat_ok;
	logic              last_beat;

	// Request for one bank; bit 5 picks the bank
	function automatic dbus_pkg::ahb_mst_t bank_req(
		input dbus_pkg::htrans_e trans,
		input logic              wr,
		input dbus_pkg::addr_t   line,
		input dbus_pkg::beat_t   beat,
		input logic              sel,
		input dbus_pkg::word_t   wdata
	);
		dbus_pkg::ahb_mst_t req;
		req.htrans = trans;
		req.hwrite = wr;
		req.haddr  = {line[31:6], sel, beat, 2'b00};
		req.hburst = dbus_pkg::HBURST_WRAP8;
		req.hsize  = dbus_pkg::HSIZE_WORD;
		req.hwdata = wdata;
		return req;
	endfunction

	// ==================================================
	// Beat status
	// ==================================================
	assign active     = (state_q == dbus_pkg::NONSEQ) || (state_q == dbus_pkg::SEQ);
	assign both_ready = i_bank1.hreadyout & i_bank2.hreadyout;
	assign ready_skew = active & (i_bank1.hreadyout ^ i_bank2.hreadyout);
	// Either bank may flag the error
	assign beat_fail  = active & both_ready & (i_bank1.hresp | i_bank2.hresp);
	assign beat_ok    = active & both_ready & ~(i_bank1.hresp | i_bank2.hresp);
	assign last_beat  = (cnt_q == LAST_BEAT);

	// ==================================================
	// FSM next state
	// ==================================================
	always_comb begin
		state_d    = state_q;
		start      = 1'b0;
		o_data_err = 1'b0;
		unique case (state_q)
			dbus_pkg::IDLE: begin
				if (i_refill_req || i_wb_req) begin
					start   = 1'b1;
					state_d = dbus_pkg::NONSEQ;
				end
			end
			dbus_pkg::NONSEQ, dbus_pkg::SEQ: begin
				// Skewed banks hold the beat
				if (ready_skew) begin
					o_data_err = 1'b1;
				end else if (beat_fail) begin
					o_data_err = 1'b1;
					state_d    = dbus_pkg::IDLE;
				end else if (beat_ok) begin
					state_d = last_beat ? dbus_pkg::IDLE : dbus_pkg::SEQ;
				end
			end
			default: state_d = dbus_pkg::IDLE;
		endcase
	end

	// ==================================================
	// State, counters, sampled line
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= dbus_pkg::IDLE;
			cnt_q   <= '0;
			idx_q   <= '0;
			addr_q  <= '0;
			write_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (start) begin
				cnt_q   <= '0;
				addr_q  <= i_addr;
				// Writeback wins, always from beat 0
				write_q <= i_wb_req;
				idx_q   <= i_wb_req ? 3'd0 : i_addr[4:2];
			end else if (beat_ok) begin
				cnt_q <= cnt_q + 1'b1;
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	// Bank ports
	assign o_bank1 = bank_req(state_q, write_q, addr_q, idx_q, 1'b0, i_dirty_w1);
	assign o_bank2 = bank_req(state_q, write_q, addr_q, idx_q, 1'b1, i_dirty_w2);

	// Refill beat to the cache
	assign o_line.update = beat_ok & ~write_q;
	assign o_line.beat   = idx_q;
	assign o_line.w1     = i_bank1.hrdata;
	assign o_line.w2     = i_bank2.hrdata;

	// Last writeback beat accepted
	assign o_wb_done = beat_ok & write_q & last_beat;

endmodule

`default_nettype wire

// File: design/dbus_pkg.sv
// Shared types for the data-side bus unit
// Address, word and beat widths
// AHB transfer, burst and size codes
// Master, slave, access and refill structs

`default_nettype none

package dbus_pkg;

	// ==================================================
	// Widths with a meaning
	// ==================================================

	// Byte address
	typedef logic [31:0] addr_t;

	// One data word
	typedef logic [31:0] word_t;

	// Beat index inside an eight-beat line
	typedef logic [2:0] beat_t;

	// ==================================================
	// AHB codes
	// ==================================================

	// Transfer type, BUSY never issued here
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	localparam logic [2:0] HBURST_SINGLE = 3'b000;
	localparam logic [2:0] HBURST_WRAP8  = 3'b100;
	localparam logic [2:0] HSIZE_WORD    = 3'b010;

	// ==================================================
	// Bus bundles
	// ==================================================

	// Master to slave
	typedef struct packed {
		htrans_e     htrans;
		logic        hwrite;
		addr_t       haddr;
		logic [2:0]  hburst;
		logic [2:0]  hsize;
		word_t       hwdata;
	} ahb_mst_t;

	// Slave to master
	typedef struct packed {
		logic  hreadyout;
		logic  hresp;
		word_t hrdata;
	} ahb_slv_t;

	// Memory-stage access from the pipeline
	typedef struct packed {
		logic  read;
		logic  write;
		addr_t addr;
		word_t wdata;
	} cpu_acc_t;

	// One refill beat for the cache, a word per bank
	typedef struct packed {
		logic  update;
		beat_t beat;
		word_t w1;
		word_t w2;
	} line_upd_t;

endpackage

`default_nettype wire

// File: design/dbus_unit.sv
// Data-side bus unit top level
// Access router, dual-bank burst engine, peripheral master

`timescale 1ns/10ps
`default_nettype none

module dbus_unit #(
	parameter dbus_pkg::addr_t PERI_BOUNDARY = 32'h011C
) (
	input  wire logic                clk,
	input  wire logic                rst_n,
	// Memory stage
	input  wire dbus_pkg::cpu_acc_t  i_acc,
	output dbus_pkg::word_t          o_rdata,
	output logic                     o_stall,
	// Cache side
	input  wire dbus_pkg::word_t     i_dmem_rdata,
	output logic                     o_mem_rd,
	output logic                     o_mem_wr,
	input  wire logic                i_refill_req,
	input  wire logic                i_wb_req,
	input  wire dbus_pkg::word_t     i_dirty_w1,
	input  wire dbus_pkg::word_t     i_dirty_w2,
	output dbus_pkg::line_upd_t      o_line,
	output logic                     o_wb_done,
	// Error flags
	output logic                     o_data_err,
	output logic                     o_peri_err,
	// AHB ports
	output dbus_pkg::ahb_mst_t       o_bank1,
	input  wire dbus_pkg::ahb_slv_t  i_bank1,
	output dbus_pkg::ahb_mst_t       o_bank2,
	input  wire dbus_pkg::ahb_slv_t  i_bank2,
	output dbus_pkg::ahb_mst_t       o_peri,
	input  wire dbus_pkg::ahb_slv_t  i_peri
);

	// Peripheral strobes from the router
	logic peri_rd;
	logic peri_wr;

	// ==================================================
	// Address decode
	// ==================================================
	access_router #(
		.PERI_BOUNDARY (PERI_BOUNDARY)
	) access_router_inst (
		.i_acc        (i_acc),
		.i_peri_rdata (i_peri.hrdata),
		.i_dmem_rdata (i_dmem_rdata),
		.o_peri_rd    (peri_rd),
		.o_peri_wr    (peri_wr),
		.o_mem_rd     (o_mem_rd),
		.o_mem_wr     (o_mem_wr),
		.o_rdata      (o_rdata)
	);

	// ==================================================
	// Bus masters
	// ==================================================

	// Line address taken from the access in flight
	burst_engine burst_engine_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_refill_req (i_refill_req),
		.i_wb_req     (i_wb_req),
		.i_addr       (i_acc.addr),
		.i_dirty_w1   (i_dirty_w1),
		.i_dirty_w2   (i_dirty_w2),
		.i_bank1      (i_bank1),
		.i_bank2      (i_bank2),
		.o_bank1      (o_bank1),
		.o_bank2      (o_bank2),
		.o_line       (o_line),
		.o_wb_done    (o_wb_done),
		.o_data_err   (o_data_err)
	);

	peri_master peri_master_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_rd       (peri_rd),
		.i_wr       (peri_wr),
		.i_addr     (i_acc.addr),
		.i_wdata    (i_acc.wdata),
		.i_peri     (i_peri),
		.o_peri     (o_peri),
		.o_stall    (o_stall),
		.o_peri_err (o_peri_err)
	);

endmodule

`default_nettype wire

// File: design/peri_master.sv
// SINGLE-transfer AHB master for the peripheral space
// Pipeline stall until completion
// Sticky error flag, cleared by the next transfer

`timescale 1ns/10ps
`default_nettype none

module peri_master (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               i_rd,
	input  wire logic               i_wr,
	input  wire dbus_pkg::addr_t    i_addr,
	input  wire dbus_pkg::word_t    i_wdata,
	input  wire dbus_pkg::ahb_slv_t i_peri,
	output dbus_pkg::ahb_mst_t      o_peri,
	output logic                    o_stall,
	output logic                    o_peri_err
);

	dbus_pkg::htrans_e htrans_q;
	logic              req;
	logic              done;

	assign req  = i_rd | i_wr;
	// Completing cycle, with or without error
	assign done = (htrans_q != dbus_pkg::IDLE) & i_peri.hreadyout;

	// Drops in the completing cycle
	assign o_stall = req & ~done;

	// ==================================================
	// Transfer state and error flag
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			htrans_q   <= dbus_pkg::IDLE;
			o_peri_err <= 1'b0;
		end else if (done) begin
			// An error ends the transfer too, no retry
			htrans_q   <= dbus_pkg::IDLE;
			o_peri_err <= i_peri.hresp;
		end else if (req && (htrans_q == dbus_pkg::IDLE)) begin
			htrans_q   <= dbus_pkg::NONSEQ;
			o_peri_err <= 1'b0;
		end
	end

	// Address and data straight from the access
	always_comb begin
		o_peri.htrans = htrans_q;
		o_peri.hwrite = i_wr;
		o_peri.haddr  = {i_addr[31:2], 2'b00};
		o_peri.hburst = dbus_pkg::HBURST_SINGLE;
		o_peri.hsize  = dbus_pkg::HSIZE_WORD;
		o_peri.hwdata = i_wdata;
	end

endmodule

`default_nettype wire

// File: tests/dbus_unit_checker.sv
// Bound AHB protocol checks for the data-side bus unit
// Reset state, bank pairing, address hold, stall cause

`timescale 1ns/10ps
`default_nettype none

module dbus_unit_checker (
	input wire logic               clk,
	input wire logic               rst_n,
	input wire dbus_pkg::ahb_mst_t i_bank1_req,
	input wire dbus_pkg::ahb_slv_t i_bank1_rsp,
	input wire dbus_pkg::ahb_mst_t i_bank2_req,
	input wire dbus_pkg::ahb_slv_t i_bank2_rsp,
	input wire dbus_pkg::ahb_mst_t i_peri_req,
	input wire dbus_pkg::ahb_slv_t i_peri_rsp,
	input wire logic               i_stall,
	input wire logic               i_peri_rd,
	input wire logic               i_peri_wr
);

	// Count of failed assertions for the closing summary
	int unsigned fail_cnt = 0;

	// ==================================================
	// Reset and bank pairing
	// ==================================================

	// All masters quiet right after reset
	reset_idle: assert property (@(posedge clk) $rose(rst_n) |->
		(i_bank1_req.htrans == dbus_pkg::IDLE && i_bank2_req.htrans == dbus_pkg::IDLE &&
		 i_peri_req.htrans == dbus_pkg::IDLE))
		else begin
			$error("bus master active in the cycle after reset");
			fail_cnt++;
		end

	// Both banks move as one burst
	bank_pair: assert property (@(posedge clk) disable iff (!rst_n)
		(i_bank1_req.htrans == i_bank2_req.htrans) &&
		(i_bank1_req.hwrite == i_bank2_req.hwrite))
		else begin
			$error("bank htrans or hwrite differ");
			fail_cnt++;
		end

	// ==================================================
	// Address hold under wait states
	// ==================================================
	bank1_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(i_bank1_req.htrans != dbus_pkg::IDLE && !i_bank1_rsp.hreadyout) |=>
		$stable(i_bank1_req.haddr))
		else begin
			$error("bank 1 haddr moved during a wait state");
			fail_cnt++;
		end

	bank2_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(i_bank2_req.htrans != dbus_pkg::IDLE && !i_bank2_rsp.hreadyout) |=>
		$stable(i_bank2_req.haddr))
		else begin
			$error("bank 2 haddr moved during a wait state");
			fail_cnt++;
		end

	peri_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(i_peri_req.htrans != dbus_pkg::IDLE && !i_peri_rsp.hreadyout) |=>
		$stable(i_peri_req.haddr))
		else begin
			$error("peripheral haddr moved during a wait state");
			fail_cnt++;
		end

	// Stall only on behalf of a peripheral access
	// Its transfer is on the bus by the next cycle
	stall_cause: assert property (@(posedge clk) disable iff (!rst_n)
		i_stall |=> ($past(i_peri_rd || i_peri_wr) &&
		 i_peri_req.htrans == dbus_pkg::NONSEQ))
		else begin
			$error("stall without a pending peripheral transfer");
			fail_cnt++;
		end

endmodule

`default_nettype wire

// File: tests/dbus_vectors.txt
// kind addr data wait_mask resp, all hex
// kind 0 peri wr, 1 peri rd, 2 mem rd, 3 refill, 4 writeback, 5 burst hresp, 6 bank skew, 7 peri hresp
0 0000011c cafef00d 3 0
1 0000011b 00000000 2 0
2 00000120 13579bdf 0 0
3 80000a54 00000000 3 0
4 80001f80 0d1e7700 1 0
5 40000208 00000000 1 3
6 40000330 00000000 0 5
7 00000080 00000000 1 1
0 0000001c 600dcafe 2 0
3 00002004 00000000 0 0

// File: tests/tb_dbus_unit.sv
// Testbench for the data-side bus unit
// Vector-driven tests, AHB slave models with random waits
// Per-test summary and closing counts

`timescale 1ns/10ps
`default_nettype none

module tb_dbus_unit;

	localparam dbus_pkg::addr_t BOUNDARY = 32'h011C;
	localparam int NUM_TESTS = 10;
	localparam int FIELDS    = 5;

	// Test kinds from the first column of the vectors
	localparam int KIND_PERI_WR  = 0;
	localparam int KIND_PERI_RD  = 1;
	localparam int KIND_MEM_RD   = 2;
	localparam int KIND_REFILL   = 3;
	localparam int KIND_WB       = 4;
	localparam int KIND_BURST_ER = 5;
	localparam int KIND_SKEW     = 6;
	localparam int KIND_PERI_ER  = 7;

	logic                clk;
	logic                rst_n;
	dbus_pkg::cpu_acc_t  acc;
	dbus_pkg::word_t     dmem_rdata;
	logic                refill_req;
	logic                wb_req;
	dbus_pkg::word_t     dirty_w1;
	dbus_pkg::word_t     dirty_w2;
	dbus_pkg::word_t     rdata;
	logic                mem_rd;
	logic                mem_wr;
	logic                stall;
	dbus_pkg::line_upd_t line_upd;
	logic                wb_done;
	logic                data_err;
	logic                peri_err;
	dbus_pkg::ahb_mst_t  bank1_m;
	dbus_pkg::ahb_mst_t  bank2_m;
	dbus_pkg::ahb_mst_t  peri_m;
	dbus_pkg::ahb_slv_t  bank1_s;
	dbus_pkg::ahb_slv_t  bank2_s;
	dbus_pkg::ahb_slv_t  peri_s;

	// Slave model controls
	logic        bank1_rdy;
	logic        bank2_rdy;
	logic        bank1_resp;
	logic        bank2_resp;
	logic        peri_rdy;
	logic        peri_resp;
	logic        peri_err_en;
	logic        skew_done;
	int          bank_wait;
	int          peri_wait;
	int          beats_done;
	int          err_beat;
	int          skew_beat;
	logic [31:0] wait_mask;
	logic [31:0] rng;

	// Bookkeeping
	logic [31:0] vec [0:NUM_TESTS*FIELDS-1];
	int          errors;
	int          test_errs;
	int          cycles;
	int          limit;

	// Word a slave returns for an address
	function automatic dbus_pkg::word_t mem_word(input dbus_pkg::addr_t a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
	endfunction

	// Dirty word the cache offers for a beat and bank
	function automatic dbus_pkg::word_t dirty_word(input dbus_pkg::word_t base,
			input dbus_pkg::beat_t beat, input logic bank);
		return base ^ ({28'h0, bank, beat} * 32'h1111_1111);
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Wait states for the next beat
	function automatic int next_wait();
		rng = xorshift(rng);
		return int'(rng & wait_mask);
	endfunction

	function automatic string kind_name(input int k);
		case (k)
			KIND_PERI_WR:  return "peri write";
			KIND_PERI_RD:  return "peri read";
			KIND_MEM_RD:   return "mem read";
			KIND_REFILL:   return "refill";
			KIND_WB:       return "writeback";
			KIND_BURST_ER: return "burst hresp";
			KIND_SKEW:     return "bank skew";
			default:       return "peri hresp";
		endcase
	endfunction

	// ==================================================
	// DUT and slave models
	// ==================================================
	assign bank1_s = {bank1_rdy, bank1_resp, mem_word(bank1_m.haddr)};
	assign bank2_s = {bank2_rdy, bank2_resp, mem_word(bank2_m.haddr)};
	assign peri_s  = {peri_rdy, peri_resp, mem_word(peri_m.haddr)};

	dbus_unit #(
		.PERI_BOUNDARY (BOUNDARY)
	) dbus_unit_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_acc        (acc),
		.o_rdata      (rdata),
		.o_stall      (stall),
		.i_dmem_rdata (dmem_rdata),
		.o_mem_rd     (mem_rd),
		.o_mem_wr     (mem_wr),
		.i_refill_req (refill_req),
		.i_wb_req     (wb_req),
		.i_dirty_w1   (dirty_w1),
		.i_dirty_w2   (dirty_w2),
		.o_line       (line_upd),
		.o_wb_done    (wb_done),
		.o_data_err   (data_err),
		.o_peri_err   (peri_err),
		.o_bank1      (bank1_m),
		.i_bank1      (bank1_s),
		.o_bank2      (bank2_m),
		.i_bank2      (bank2_s),
		.o_peri       (peri_m),
		.i_peri       (peri_s)
	);

	bind dbus_unit dbus_unit_checker checker_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_bank1_req (o_bank1),
		.i_bank1_rsp (i_bank1),
		.i_bank2_req (o_bank2),
		.i_bank2_rsp (i_bank2),
		.i_peri_req  (o_peri),
		.i_peri_rsp  (i_peri),
		.i_stall     (o_stall),
		.i_peri_rd   (peri_rd),
		.i_peri_wr   (peri_wr)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Watchdog with its limit set once the vectors are read
	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT never finished its tests", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	// ==================================================
	// Helper tasks
	// ==================================================
	task automatic expect_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("Problem at t=%0t: %s", $time, what);
		errors++;
		test_errs++;
	endtask

	// Slave decisions at the falling edge before the outputs settle
	task automatic respond();
		bank1_resp = 1'b0;
		bank2_resp = 1'b0;
		peri_resp  = 1'b0;
		if (bank1_m.htrans == dbus_pkg::IDLE) begin
			bank1_rdy = 1'b1;
			bank2_rdy = 1'b1;
			bank_wait = next_wait();
		end else if (bank_wait != 0) begin
			bank1_rdy = 1'b0;
			bank2_rdy = 1'b0;
			bank_wait--;
		end else if (beats_done == skew_beat && !skew_done) begin
			// Bank 2 lags one cycle behind bank 1
			bank1_rdy = 1'b1;
			bank2_rdy = 1'b0;
			skew_done = 1'b1;
		end else begin
			bank1_rdy  = 1'b1;
			bank2_rdy  = 1'b1;
			bank2_resp = (beats_done == err_beat);
			bank_wait  = next_wait();
		end
		if (peri_m.htrans == dbus_pkg::IDLE) begin
			peri_rdy  = 1'b1;
			peri_wait = next_wait();
		end else if (peri_wait != 0) begin
			peri_rdy = 1'b0;
			peri_wait--;
		end else begin
			peri_rdy  = 1'b1;
			peri_resp = peri_err_en;
			peri_wait = next_wait();
		end
		#1;
	endtask

	// ==================================================
	// Peripheral and routed accesses
	// ==================================================
	task automatic peri_access(input int kind, input dbus_pkg::addr_t addr,
			input dbus_pkg::word_t data);
		logic            wr;
		logic            fin;
		dbus_pkg::addr_t al;
		wr          = (kind == KIND_PERI_WR);
		al          = {addr[31:2], 2'b00};
		peri_err_en = (kind == KIND_PERI_ER);
		fin         = 1'b0;
		@(negedge clk);
		acc.read  = !wr;
		acc.write = wr;
		acc.addr  = addr;
		acc.wdata = data;
		respond();
		expect_eq("o_stall", stall, 1'b1);
		expect_eq("o_peri.htrans", peri_m.htrans, dbus_pkg::IDLE);
		while (!fin) begin
			@(negedge clk);
			respond();
			expect_eq("o_mem_wr", mem_wr, 1'b0);
			expect_eq("o_mem_rd", mem_rd, 1'b0);
			if (peri_m.htrans == dbus_pkg::IDLE) begin
				report_problem("peripheral transfer never started");
				fin = 1'b1;
			end else begin
				expect_eq("o_peri.haddr", peri_m.haddr, al);
				expect_eq("o_peri.hwrite", peri_m.hwrite, wr);
				expect_eq("o_peri.hburst", peri_m.hburst, dbus_pkg::HBURST_SINGLE);
				// Flag cleared as the transfer started
				expect_eq("o_peri_err", peri_err, 1'b0);
				if (wr)
					expect_eq("o_peri.hwdata", peri_m.hwdata, data);
				if (peri_rdy) begin
					expect_eq("o_stall", stall, 1'b0);
					if (!wr && !peri_err_en)
						expect_eq("o_rdata", rdata, mem_word(al));
					fin = 1'b1;
				end else begin
					expect_eq("o_stall", stall, 1'b1);
				end
			end
		end
		@(negedge clk);
		acc = '0;
		respond();
		expect_eq("o_peri.htrans", peri_m.htrans, dbus_pkg::IDLE);
		expect_eq("o_stall", stall, 1'b0);
		expect_eq("o_peri_err", peri_err, peri_err_en);
		peri_err_en = 1'b0;
	endtask

	task automatic mem_read(input dbus_pkg::addr_t addr, input dbus_pkg::word_t data);
		@(negedge clk);
		acc.read   = 1'b1;
		acc.write  = 1'b0;
		acc.addr   = addr;
		acc.wdata  = '0;
		dmem_rdata = data;
		respond();
		expect_eq("o_mem_rd", mem_rd, 1'b1);
		expect_eq("o_mem_wr", mem_wr, 1'b0);
		expect_eq("o_stall", stall, 1'b0);
		expect_eq("o_rdata", rdata, data);
		@(negedge clk);
		acc = '0;
		respond();
		expect_eq("o_peri.htrans", peri_m.htrans, dbus_pkg::IDLE);
	endtask

	// ==================================================
	// Bursts for refill, writeback and error cases
	// ==================================================
	task automatic line_burst(input int kind, input dbus_pkg::addr_t addr,
			input dbus_pkg::word_t data, input int resp);
		dbus_pkg::beat_t exp_beat;
		dbus_pkg::addr_t exp_a1;
		dbus_pkg::addr_t exp_a2;
		logic            wb;
		logic            running;
		wb         = (kind == KIND_WB);
		exp_beat   = wb ? 3'd0 : addr[4:2];
		beats_done = 0;
		err_beat   = (kind == KIND_BURST_ER) ? resp : -1;
		skew_beat  = (kind == KIND_SKEW) ? resp : -1;
		skew_done  = 1'b0;
		running    = 1'b1;
		// Request cycle where the engine samples the address
		@(negedge clk);
		acc        = '0;
		acc.addr   = addr;
		wb_req     = wb;
		refill_req = !wb;
		respond();
		expect_eq("o_bank1.htrans", bank1_m.htrans, dbus_pkg::IDLE);
		expect_eq("o_line.update", line_upd.update, 1'b0);
		while (running) begin
			@(negedge clk);
			refill_req = 1'b0;
			wb_req     = 1'b0;
			dirty_w1   = dirty_word(data, line_upd.beat, 1'b0);
			dirty_w2   = dirty_word(data, line_upd.beat, 1'b1);
			respond();
			if (bank1_m.htrans == dbus_pkg::IDLE) begin
				report_problem("burst engine went idle before the line finished");
				running = 1'b0;
			end else begin
				exp_a1 = {addr[31:6], 1'b0, exp_beat, 2'b00};
				exp_a2 = {addr[31:6], 1'b1, exp_beat, 2'b00};
				// First beat is NONSEQ and the rest SEQ
				expect_eq("o_bank1.htrans", bank1_m.htrans,
					(beats_done == 0) ? dbus_pkg::NONSEQ : dbus_pkg::SEQ);
				expect_eq("o_bank1.hburst", bank1_m.hburst, dbus_pkg::HBURST_WRAP8);
				expect_eq("o_bank1.haddr", bank1_m.haddr, exp_a1);
				expect_eq("o_bank2.haddr", bank2_m.haddr, exp_a2);
				expect_eq("o_bank1.hwrite", bank1_m.hwrite, wb);
				if (bank1_rdy && bank2_rdy && bank2_resp) begin
					expect_eq("o_data_err", data_err, 1'b1);
					expect_eq("o_line.update", line_upd.update, 1'b0);
					running = 1'b0;
				end else if (bank1_rdy && bank2_rdy) begin
					expect_eq("o_data_err", data_err, 1'b0);
					expect_eq("o_wb_done", wb_done, wb && (beats_done == 7));
					expect_eq("o_line.update", line_upd.update, !wb);
					if (wb) begin
						expect_eq("o_bank1.hwdata", bank1_m.hwdata,
							dirty_word(data, exp_beat, 1'b0));
						expect_eq("o_bank2.hwdata", bank2_m.hwdata,
							dirty_word(data, exp_beat, 1'b1));
					end else begin
						expect_eq("o_line.beat", line_upd.beat, exp_beat);
						expect_eq("o_line.w1", line_upd.w1, mem_word(exp_a1));
						expect_eq("o_line.w2", line_upd.w2, mem_word(exp_a2));
					end
					exp_beat = exp_beat + 3'd1;
					beats_done++;
					running = (beats_done < 8);
				end else begin
					// Skew flags an error but plain waits do not
					expect_eq("o_data_err", data_err, bank1_rdy != bank2_rdy);
					expect_eq("o_line.update", line_upd.update, 1'b0);
					expect_eq("o_wb_done", wb_done, 1'b0);
				end
			end
		end
		@(negedge clk);
		respond();
		expect_eq("o_bank1.htrans", bank1_m.htrans, dbus_pkg::IDLE);
		expect_eq("o_data_err", data_err, 1'b0);
		expect_eq("o_wb_done", wb_done, 1'b0);
		err_beat  = -1;
		skew_beat = -1;
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int              t;
		int              kind;
		int              resp;
		int              chk_fails;
		dbus_pkg::addr_t addr;
		dbus_pkg::word_t data;
		limit = 0;
		$readmemh("tests/dbus_vectors.txt", vec);
		rst_n       = 1'b0;
		acc         = '0;
		dmem_rdata  = '0;
		refill_req  = 1'b0;
		wb_req      = 1'b0;
		dirty_w1    = '0;
		dirty_w2    = '0;
		bank1_rdy   = 1'b1;
		bank2_rdy   = 1'b1;
		bank1_resp  = 1'b0;
		bank2_resp  = 1'b0;
		peri_rdy    = 1'b1;
		peri_resp   = 1'b0;
		peri_err_en = 1'b0;
		skew_done   = 1'b0;
		bank_wait   = 0;
		peri_wait   = 0;
		beats_done  = 0;
		err_beat    = -1;
		skew_beat   = -1;
		wait_mask   = '0;
		rng         = 32'h51dd3f5d;
		errors      = 0;
		// Ten cycles per beat and eight beats per burst
		for (t = 0; t < NUM_TESTS; t++) begin
			kind  = int'(vec[t*FIELDS]);
			limit = limit + ((kind >= KIND_REFILL && kind <= KIND_SKEW) ? 80 : 10);
		end
		limit = limit + 20;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (t = 0; t < NUM_TESTS; t++) begin
			kind      = int'(vec[t*FIELDS]);
			addr      = vec[t*FIELDS+1];
			data      = vec[t*FIELDS+2];
			wait_mask = vec[t*FIELDS+3];
			resp      = int'(vec[t*FIELDS+4]);
			test_errs = 0;
			case (kind)
				KIND_PERI_WR, KIND_PERI_RD, KIND_PERI_ER: peri_access(kind, addr, data);
				KIND_MEM_RD: mem_read(addr, data);
				default:     line_burst(kind, addr, data, resp);
			endcase
			$display("test %0d %s at %h: %0d errors", t, kind_name(kind), addr, test_errs);
		end
		chk_fails = dbus_unit_inst.checker_inst.fail_cnt;
		$display("%0d tests, %0d check errors, %0d assertion failures",
			NUM_TESTS, errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
